// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert -f build.f --top-module proc_tb -o Vproc_tb
	./obj_dir/Vproc_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "TB FAILED" $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: build.f
common/proc_pkg.sv
design/apb_debug.sv
fetch/fetch.sv
decode/reg_file.sv
decode/decode.sv
execute/execute.sv
design/proc.sv
verification/proc_tb.sv

// File: common/proc_pkg.sv
// --------------------------------------
// Widths are fixed by the 16-bit instruction format
// Addresses are byte addresses, word aligned
// --------------------------------------
package proc_pkg;

   localparam int IMEM_DEPTH = 256;
   localparam int NUM_REGS = 8;

   typedef logic [15:0] word_t;
   typedef logic [15:0] instr_t;
   typedef logic [2:0] reg_idx_t;
   typedef logic [7:0] pc_t;

   // Opcodes in instr[15:11]
   localparam logic [4:0] OP_HALT = 5'd0;
   localparam logic [4:0] OP_NOP = 5'd1;
   localparam logic [4:0] OP_ADDI = 5'd8;
   localparam logic [4:0] OP_LBI = 5'd24;
   localparam logic [4:0] OP_RTYPE = 5'd27;

   // APB address map
   localparam logic [11:0] ADDR_IMEM_BASE = 12'h000;
   localparam logic [11:0] ADDR_REG_BASE = 12'h400;
   localparam logic [11:0] ADDR_CTRL = 12'h800;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_AND,
      ALU_PASS
   } alu_op_t;

   typedef enum logic {
      DEC_RUN,
      DEC_HALTED
   } dec_state_t;

   typedef struct packed {
      logic psel;
      logic penable;
      logic pwrite;
      logic [11:0] paddr;
      logic [31:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [31:0] prdata;
      logic pready;
      logic pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic start;
      logic run;
   } core_ctrl_t;

   typedef struct packed {
      logic en;
      pc_t addr;
      instr_t data;
   } imem_wr_t;

   typedef struct packed {
      logic valid;
      instr_t instr;
   } fetch_out_t;

   typedef struct packed {
      logic valid;
      alu_op_t alu_op;
      word_t a;
      word_t b;
      reg_idx_t rd;
      logic we;
      logic halt;
      logic illegal;
   } dec_to_ex_t;

   typedef struct packed {
      logic valid;
      logic we;
      reg_idx_t rd;
      word_t data;
      logic halt;
      logic illegal;
   } wb_t;

endpackage

// File: decode/decode.sv
// --------------------------------------
// Stalls only on a producer one slot ahead,
// reg_file write-through covers two slots
// --------------------------------------
`timescale 1ns/1ps

module decode (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::core_ctrl_t ctrl,
   input  proc_pkg::fetch_out_t fetch_out,
   output proc_pkg::reg_idx_t rs_idx,
   output proc_pkg::reg_idx_t rt_idx,
   input  proc_pkg::word_t rs_data,
   input  proc_pkg::word_t rt_data,
   output logic stall,
   output proc_pkg::dec_to_ex_t dec_to_ex
);

   proc_pkg::instr_t instr;
   logic [4:0] opcode;
   logic uses_rs;
   logic uses_rt;
   logic hazard;
   logic running;
   proc_pkg::dec_state_t dec_state;
   proc_pkg::dec_to_ex_t dec_d;

   assign instr = fetch_out.instr;
   assign opcode = instr[15:11];
   assign rs_idx = instr[10:8];
   assign rt_idx = instr[7:5];

   always_comb begin
      dec_d = '0;
      dec_d.alu_op = proc_pkg::ALU_ADD;
      dec_d.a = rs_data;
      dec_d.b = rt_data;
      dec_d.rd = instr[4:2];
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      case (opcode)
         proc_pkg::OP_RTYPE: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
            dec_d.we = 1'b1;
            case (instr[1:0])
               2'b00: dec_d.alu_op = proc_pkg::ALU_ADD;
               2'b01: dec_d.alu_op = proc_pkg::ALU_SUB;
               2'b10: dec_d.alu_op = proc_pkg::ALU_XOR;
               default: dec_d.alu_op = proc_pkg::ALU_AND;
            endcase
         end
         proc_pkg::OP_ADDI: begin
            uses_rs = 1'b1;
            dec_d.we = 1'b1;
            dec_d.b = {{11{instr[4]}}, instr[4:0]};
            dec_d.rd = instr[7:5];
         end
         proc_pkg::OP_LBI: begin
            dec_d.we = 1'b1;
            dec_d.alu_op = proc_pkg::ALU_PASS;
            dec_d.b = {{8{instr[7]}}, instr[7:0]};
            dec_d.rd = instr[10:8];
         end
         proc_pkg::OP_NOP: ;
         proc_pkg::OP_HALT: dec_d.halt = 1'b1;
         default: dec_d.illegal = 1'b1;
      endcase

      hazard = dec_to_ex.valid && dec_to_ex.we &&
               ((uses_rs && dec_to_ex.rd == rs_idx) || (uses_rt && dec_to_ex.rd == rt_idx));
      running = fetch_out.valid && dec_state == proc_pkg::DEC_RUN;
      // Bubble goes out while stalled
      dec_d.valid = running && !hazard;
   end

   assign stall = running && hazard;

   always_ff @(posedge clk) begin
      if (rst || ctrl.start) begin
         dec_state <= proc_pkg::DEC_RUN;
         dec_to_ex.valid <= 1'b0;
      end else begin
         dec_to_ex <= dec_d;
         if (dec_d.valid && (dec_d.halt || dec_d.illegal)) begin
            dec_state <= proc_pkg::DEC_HALTED;
         end
      end
   end

   // One bubble always clears the hazard
   stall_one_cycle: assert property (
      @(posedge clk) disable iff (rst) stall |=> !stall
   );

endmodule

// File: decode/reg_file.sv
// --------------------------------------
// Writes bypass to the read ports in the same cycle
// --------------------------------------
`timescale 1ns/1ps

module reg_file (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::reg_idx_t rs_idx,
   input  proc_pkg::reg_idx_t rt_idx,
   input  proc_pkg::reg_idx_t dbg_idx,
   output proc_pkg::word_t rs_data,
   output proc_pkg::word_t rt_data,
   output proc_pkg::word_t dbg_data,
   input  proc_pkg::wb_t wb
);

   proc_pkg::word_t regs [proc_pkg::NUM_REGS];
   logic wr_en;

   assign wr_en = wb.valid && wb.we;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < proc_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wb.rd] <= wb.data;
      end
   end

   assign rs_data = (wr_en && wb.rd == rs_idx) ? wb.data : regs[rs_idx];
   assign rt_data = (wr_en && wb.rd == rt_idx) ? wb.data : regs[rt_idx];
   assign dbg_data = regs[dbg_idx];

endmodule

// File: design/apb_debug.sv
// --------------------------------------
// Zero wait states, instruction memory is write only
// and reads back as zero
// --------------------------------------
`timescale 1ns/1ps

module apb_debug (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::apb_req_t apb_req,
   output proc_pkg::apb_rsp_t apb_rsp,
   output proc_pkg::core_ctrl_t ctrl,
   output proc_pkg::imem_wr_t imem_wr,
   output proc_pkg::reg_idx_t dbg_idx,
   input  proc_pkg::word_t dbg_data,
   input  proc_pkg::wb_t wb,
   output logic err
);

   logic access;
   logic aligned;
   logic imem_hit;
   logic reg_hit;
   logic ctrl_hit;
   logic bad;
   logic start_wr;
   logic stop;
   logic halted;

   assign access = apb_req.psel && apb_req.penable;
   assign aligned = apb_req.paddr[1:0] == 2'b00;
   assign imem_hit = aligned && (apb_req.paddr < proc_pkg::ADDR_REG_BASE);
   assign reg_hit = aligned && (apb_req.paddr[11:5] == proc_pkg::ADDR_REG_BASE[11:5]);
   assign ctrl_hit = apb_req.paddr == proc_pkg::ADDR_CTRL;

   // Unmapped, register space write, or loading a running core
   assign bad = !(imem_hit || reg_hit || ctrl_hit) ||
                (apb_req.pwrite && reg_hit) ||
                (apb_req.pwrite && imem_hit && ctrl.run);

   assign dbg_idx = apb_req.paddr[4:2];

   always_comb begin
      apb_rsp.prdata = '0;
      apb_rsp.pready = 1'b1;
      apb_rsp.pslverr = access && bad;
      if (reg_hit) begin
         apb_rsp.prdata = {16'h0, dbg_data};
      end else if (ctrl_hit) begin
         apb_rsp.prdata = {29'h0, err, halted, ctrl.run};
      end
   end

   always_comb begin
      imem_wr.en = access && apb_req.pwrite && imem_hit && !ctrl.run;
      imem_wr.addr = apb_req.paddr[9:2];
      imem_wr.data = apb_req.pwdata[15:0];
   end

   assign start_wr = access && apb_req.pwrite && ctrl_hit && apb_req.pwdata[0];
   assign stop = wb.valid && (wb.halt || wb.illegal);

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl <= '0;
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         ctrl.start <= start_wr;
         if (start_wr) begin
            ctrl.run <= 1'b1;
            halted <= 1'b0;
         end else if (stop) begin
            ctrl.run <= 1'b0;
            halted <= 1'b1;
         end
         // Sticky until reset
         if (stop && wb.illegal) begin
            err <= 1'b1;
         end
      end
   end

   penable_needs_psel: assert property (
      @(posedge clk) disable iff (rst) apb_req.penable |-> apb_req.psel
   );

endmodule

// File: design/proc.sv
// --------------------------------------
// Core is loaded, started and observed over APB only
// --------------------------------------
`timescale 1ns/1ps

module proc (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::apb_req_t apb_req,
   output proc_pkg::apb_rsp_t apb_rsp,
   output logic err
);

   proc_pkg::core_ctrl_t ctrl;
   proc_pkg::imem_wr_t imem_wr;
   proc_pkg::fetch_out_t fetch_out;
   proc_pkg::dec_to_ex_t dec_to_ex;
   proc_pkg::wb_t wb;
   proc_pkg::reg_idx_t rs_idx;
   proc_pkg::reg_idx_t rt_idx;
   proc_pkg::reg_idx_t dbg_idx;
   proc_pkg::word_t rs_data;
   proc_pkg::word_t rt_data;
   proc_pkg::word_t dbg_data;
   logic stall;

   apb_debug apb_debug0 (
      .clk(clk),
      .rst(rst),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .ctrl(ctrl),
      .imem_wr(imem_wr),
      .dbg_idx(dbg_idx),
      .dbg_data(dbg_data),
      .wb(wb),
      .err(err)
   );

   fetch fetch0 (
      .clk(clk),
      .rst(rst),
      .ctrl(ctrl),
      .stall(stall),
      .imem_wr(imem_wr),
      .fetch_out(fetch_out)
   );

   decode decode0 (
      .clk(clk),
      .rst(rst),
      .ctrl(ctrl),
      .fetch_out(fetch_out),
      .rs_idx(rs_idx),
      .rt_idx(rt_idx),
      .rs_data(rs_data),
      .rt_data(rt_data),
      .stall(stall),
      .dec_to_ex(dec_to_ex)
   );

   reg_file reg_file0 (
      .clk(clk),
      .rst(rst),
      .rs_idx(rs_idx),
      .rt_idx(rt_idx),
      .dbg_idx(dbg_idx),
      .rs_data(rs_data),
      .rt_data(rt_data),
      .dbg_data(dbg_data),
      .wb(wb)
   );

   execute execute0 (
      .clk(clk),
      .rst(rst),
      .dec_to_ex(dec_to_ex),
      .wb(wb)
   );

endmodule

// File: execute/execute.sv
// --------------------------------------
// Arithmetic wraps modulo 2^16, no flags
// --------------------------------------
`timescale 1ns/1ps

module execute (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::dec_to_ex_t dec_to_ex,
   output proc_pkg::wb_t wb
);

   proc_pkg::word_t result;

   always_comb begin
      case (dec_to_ex.alu_op)
         proc_pkg::ALU_ADD: result = dec_to_ex.a + dec_to_ex.b;
         proc_pkg::ALU_SUB: result = dec_to_ex.a - dec_to_ex.b;
         proc_pkg::ALU_XOR: result = dec_to_ex.a ^ dec_to_ex.b;
         proc_pkg::ALU_AND: result = dec_to_ex.a & dec_to_ex.b;
         default: result = dec_to_ex.b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wb.valid <= 1'b0;
      end else begin
         wb.valid <= dec_to_ex.valid;
         wb.we <= dec_to_ex.we;
         wb.rd <= dec_to_ex.rd;
         wb.data <= result;
         wb.halt <= dec_to_ex.halt;
         wb.illegal <= dec_to_ex.illegal;
      end
   end

   // Halt commits without touching the register file
   halt_never_writes: assert property (
      @(posedge clk) disable iff (rst) (wb.valid && wb.we) |-> !wb.halt
   );

endmodule

// File: fetch/fetch.sv
// --------------------------------------
// Synchronous read memory, PC wraps at 256 words
// --------------------------------------
`timescale 1ns/1ps

module fetch (
   input  logic clk,
   input  logic rst,
   input  proc_pkg::core_ctrl_t ctrl,
   input  logic stall,
   input  proc_pkg::imem_wr_t imem_wr,
   output proc_pkg::fetch_out_t fetch_out
);

   proc_pkg::instr_t imem [proc_pkg::IMEM_DEPTH];
   proc_pkg::pc_t pc;

   always_ff @(posedge clk) begin
      if (imem_wr.en) begin
         imem[imem_wr.addr] <= imem_wr.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
         fetch_out.valid <= 1'b0;
      end else if (ctrl.start) begin
         pc <= '0;
         fetch_out.valid <= 1'b0;
      end else if (ctrl.run && !stall) begin
         pc <= pc + 1'b1;
         fetch_out.valid <= 1'b1;
         fetch_out.instr <= imem[pc];
      end else if (!ctrl.run) begin
         fetch_out.valid <= 1'b0;
      end
      // stall holds PC and fetch register
   end

   // Debug port must keep out while the core runs
   no_load_while_running: assert property (
      @(posedge clk) disable iff (rst) imem_wr.en |-> !ctrl.run
   );

endmodule

// File: verification/proc_tb.sv
// --------------------------------------
// Drives the core only through its APB debug port
// Register state carries over between programs
// --------------------------------------
`timescale 1ns/1ps

module proc_tb;

   localparam int NUM_RAND = 20;
   localparam int RAND_LEN = 16;
   localparam int MAX_PROG = 24;
   // Per program: APB load, run with stalls, status polls, register reads
   localparam int TIMEOUT_CYCLES = (NUM_RAND + 5) * (MAX_PROG * 8 + 100) + 200;
   localparam logic [31:0] SEED = 32'he07c1ff2;

   logic clk = 1'b0;
   logic rst;
   proc_pkg::apb_req_t apb_req;
   proc_pkg::apb_rsp_t apb_rsp;
   logic err;

   proc_pkg::instr_t prog [$];
   logic [15:0] model_regs [8];
   logic exp_err;
   logic [31:0] rng;

   proc dut0 (
      .clk(clk),
      .rst(rst),
      .apb_req(apb_req),
      .apb_rsp(apb_rsp),
      .err(err)
   );

   always #50 clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp) else begin
         $display("Fail at %0t: %s expected 0x%h actual 0x%h", $time, name, exp, act);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Setup phase, access phase, then back to idle
   task automatic apb_access(input logic write, input logic [11:0] addr,
                             input logic [31:0] wdata, input logic exp_slverr,
                             output logic [31:0] rdata);
      @(posedge clk);
      apb_req.psel <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite <= write;
      apb_req.paddr <= addr;
      apb_req.pwdata <= wdata;
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      check_value("pready", 32'h1, {31'h0, apb_rsp.pready});
      check_value("pslverr", {31'h0, exp_slverr}, {31'h0, apb_rsp.pslverr});
      rdata = apb_rsp.prdata;
      @(posedge clk);
      apb_req.psel <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   function automatic proc_pkg::instr_t lbi_instr(input logic [2:0] rd, input logic [7:0] imm);
      return {proc_pkg::OP_LBI, rd, imm};
   endfunction

   function automatic proc_pkg::instr_t addi_instr(input logic [2:0] rd, input logic [2:0] rs,
                                                   input logic [4:0] imm);
      return {proc_pkg::OP_ADDI, rs, rd, imm};
   endfunction

   function automatic proc_pkg::instr_t rtype_instr(input logic [2:0] rd, input logic [2:0] rs,
                                                    input logic [2:0] rt, input logic [1:0] ext);
      return {proc_pkg::OP_RTYPE, rs, rt, rd, ext};
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ISA level execution, stops at halt or an illegal opcode
   task automatic model_run;
      proc_pkg::instr_t ins;
      logic [15:0] a;
      logic [15:0] b;
      logic done;
      done = 1'b0;
      for (int i = 0; i < prog.size() && !done; i++) begin
         ins = prog[i];
         a = model_regs[ins[10:8]];
         b = model_regs[ins[7:5]];
         case (ins[15:11])
            proc_pkg::OP_LBI: model_regs[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
            proc_pkg::OP_ADDI: model_regs[ins[7:5]] = a + {{11{ins[4]}}, ins[4:0]};
            proc_pkg::OP_RTYPE: begin
               case (ins[1:0])
                  2'd0: model_regs[ins[4:2]] = a + b;
                  2'd1: model_regs[ins[4:2]] = a - b;
                  2'd2: model_regs[ins[4:2]] = a ^ b;
                  default: model_regs[ins[4:2]] = a & b;
               endcase
            end
            proc_pkg::OP_NOP: ;
            proc_pkg::OP_HALT: done = 1'b1;
            default: begin
               exp_err = 1'b1;
               done = 1'b1;
            end
         endcase
      end
   endtask

   task automatic load_program;
      logic [31:0] rdata;
      for (int i = 0; i < prog.size(); i++) begin
         apb_access(1'b1, proc_pkg::ADDR_IMEM_BASE + 12'(i * 4), {16'h0, prog[i]}, 1'b0, rdata);
      end
   endtask

   task automatic start_core;
      logic [31:0] rdata;
      apb_access(1'b1, proc_pkg::ADDR_CTRL, 32'h1, 1'b0, rdata);
   endtask

   task automatic wait_halted;
      logic [31:0] status;
      status = '0;
      while (!status[1]) begin
         apb_access(1'b0, proc_pkg::ADDR_CTRL, 32'h0, 1'b0, status);
      end
      check_value("ctrl status", {29'h0, exp_err, 2'b10}, status);
   endtask

   task automatic check_regs;
      logic [31:0] rdata;
      for (int i = 0; i < 8; i++) begin
         apb_access(1'b0, proc_pkg::ADDR_REG_BASE + 12'(i * 4), 32'h0, 1'b0, rdata);
         check_value($sformatf("r%0d", i), {16'h0, model_regs[i]}, rdata);
      end
      check_value("err", {31'h0, exp_err}, {31'h0, err});
   endtask

   task automatic run_program;
      model_run();
      load_program();
      start_core();
      wait_halted();
      check_regs();
   endtask

   task automatic random_program;
      logic [4:0] op;
      prog.delete();
      for (int i = 0; i < RAND_LEN; i++) begin
         rng = xorshift(rng);
         case (rng[31:30])
            2'd0: op = proc_pkg::OP_LBI;
            2'd1: op = proc_pkg::OP_ADDI;
            2'd2: op = proc_pkg::OP_RTYPE;
            default: op = proc_pkg::OP_NOP;
         endcase
         prog.push_back({op, rng[10:0]});
      end
      prog.push_back({proc_pkg::OP_HALT, 11'h0});
   endtask

   initial begin
      logic [31:0] rdata;
      rst = 1'b1;
      apb_req = '0;
      exp_err = 1'b0;
      rng = SEED;
      for (int i = 0; i < 8; i++) begin
         model_regs[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);

      // Idle core after reset
      apb_access(1'b0, proc_pkg::ADDR_CTRL, 32'h0, 1'b0, rdata);
      check_value("ctrl status", 32'h0, rdata);
      check_regs();

      // Straight line, each R-type extension
      prog.delete();
      prog.push_back(lbi_instr(3'd0, 8'h12));
      prog.push_back(lbi_instr(3'd1, 8'h85));
      prog.push_back(lbi_instr(3'd2, 8'h7f));
      prog.push_back(lbi_instr(3'd3, 8'hf0));
      prog.push_back(lbi_instr(3'd4, 8'h33));
      prog.push_back(lbi_instr(3'd5, 8'h01));
      prog.push_back({proc_pkg::OP_NOP, 11'h0});
      prog.push_back(rtype_instr(3'd6, 3'd0, 3'd1, 2'd0));
      prog.push_back(rtype_instr(3'd7, 3'd2, 3'd3, 2'd1));
      prog.push_back(addi_instr(3'd5, 3'd4, 5'h1d));
      prog.push_back(rtype_instr(3'd0, 3'd1, 3'd3, 2'd2));
      prog.push_back(rtype_instr(3'd1, 3'd2, 3'd4, 2'd3));
      prog.push_back({proc_pkg::OP_HALT, 11'h0});
      run_program();

      // Back to back dependencies, then distance two
      prog.delete();
      prog.push_back(lbi_instr(3'd1, 8'h05));
      prog.push_back(addi_instr(3'd1, 3'd1, 5'h07));
      prog.push_back(rtype_instr(3'd2, 3'd1, 3'd1, 2'd0));
      prog.push_back(rtype_instr(3'd3, 3'd2, 3'd1, 2'd1));
      prog.push_back(rtype_instr(3'd3, 3'd3, 3'd2, 2'd2));
      prog.push_back(addi_instr(3'd3, 3'd3, 5'h1f));
      prog.push_back(rtype_instr(3'd4, 3'd3, 3'd2, 2'd3));
      prog.push_back(lbi_instr(3'd6, 8'hfe));
      prog.push_back({proc_pkg::OP_NOP, 11'h0});
      prog.push_back(addi_instr(3'd6, 3'd6, 5'h10));
      prog.push_back(rtype_instr(3'd7, 3'd6, 3'd4, 2'd0));
      prog.push_back({proc_pkg::OP_HALT, 11'h0});
      run_program();

      for (int n = 0; n < NUM_RAND; n++) begin
         random_program();
         run_program();
      end

      // Opcode 3 is unassigned
      prog.delete();
      prog.push_back(lbi_instr(3'd1, 8'h09));
      prog.push_back(addi_instr(3'd2, 3'd1, 5'h01));
      prog.push_back({5'd3, 11'h0});
      prog.push_back(lbi_instr(3'd3, 8'h55));
      prog.push_back(addi_instr(3'd4, 3'd1, 5'h02));
      prog.push_back({proc_pkg::OP_HALT, 11'h0});
      run_program();

      // Slave errors while a NOP program runs
      prog.delete();
      for (int i = 0; i < 8; i++) begin
         prog.push_back({proc_pkg::OP_NOP, 11'h0});
      end
      prog.push_back({proc_pkg::OP_HALT, 11'h0});
      model_run();
      load_program();
      start_core();
      apb_access(1'b1, 12'h010, {16'h0, lbi_instr(3'd0, 8'haa)}, 1'b1, rdata);
      apb_access(1'b1, 12'h600, 32'h0, 1'b1, rdata);
      apb_access(1'b0, 12'h002, 32'h0, 1'b1, rdata);
      apb_access(1'b1, proc_pkg::ADDR_REG_BASE + 12'h4, 32'hffff, 1'b1, rdata);
      wait_halted();
      apb_access(1'b0, proc_pkg::ADDR_IMEM_BASE, 32'h0, 1'b0, rdata);
      check_regs();

      $display("TB PASSED");
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the core never reported halted within the cycle limit");
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule
